//--- hdl/uart_cfg.svh
`ifndef UART_CFG_SVH
`define UART_CFG_SVH

// clock cycles per bit time, mid-bit sample at half of this
`define UART_BAUD_DIV 434

// idle bit times between the two frames of a write
`define UART_GAP_BITS 2

// bit times the remote gets to start its reply
`define UART_RSP_TIMEOUT_BITS 64

`endif

//--- hdl/uart_cmd_bridge.sv
`timescale 1ns/10ps

module uart_cmd_bridge
  import uart_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic [15:0] cmd_in,
  input  logic        cmd_vld,
  output logic        cmd_rdy,
  input  logic        rx,
  output logic        tx,
  output logic        read_rdy,
  output uart_byte_t  read_data,
  output rsp_status_t read_status
);

  logic        tx_start;
  uart_byte_t  tx_byte;
  logic        tx_done;
  logic        rx_start;
  logic        rx_valid;
  uart_byte_t  rx_byte;
  rsp_status_t rx_status;

  uart_cmd_seq uart_cmd_seq_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmd_in      (cmd_in),
    .cmd_vld     (cmd_vld),
    .cmd_rdy     (cmd_rdy),
    .tx_start    (tx_start),
    .tx_byte     (tx_byte),
    .tx_done     (tx_done),
    .rx_start    (rx_start),
    .rx_valid    (rx_valid),
    .rx_byte     (rx_byte),
    .rx_status   (rx_status),
    .read_rdy    (read_rdy),
    .read_data   (read_data),
    .read_status (read_status)
  );

  uart_tx_frame uart_tx_frame_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx_done  (tx_done),
    .tx       (tx)
  );

  // free running, the sequencer decides when its output matters
  uart_rx_frame uart_rx_frame_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .rx        (rx),
    .rx_start  (rx_start),
    .rx_valid  (rx_valid),
    .rx_byte   (rx_byte),
    .rx_status (rx_status)
  );

endmodule

//--- hdl/uart_cmd_seq.sv
`timescale 1ns/10ps
`include "uart_cfg.svh"

module uart_cmd_seq
  import uart_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic [15:0] cmd_in,
  input  logic        cmd_vld,
  output logic        cmd_rdy,
  output logic        tx_start,
  output uart_byte_t  tx_byte,
  input  logic        tx_done,
  input  logic        rx_start,
  input  logic        rx_valid,
  input  uart_byte_t  rx_byte,
  input  rsp_status_t rx_status,
  output logic        read_rdy,
  output uart_byte_t  read_data,
  output rsp_status_t read_status
);

  localparam int GAP_CYC  = `UART_GAP_BITS * `UART_BAUD_DIV;
  localparam int TMO_CYC  = `UART_RSP_TIMEOUT_BITS * `UART_BAUD_DIV;
  localparam int WAIT_MAX = (TMO_CYC > GAP_CYC) ? TMO_CYC : GAP_CYC;
  localparam int WAIT_W   = $clog2(WAIT_MAX);
  // two cycles of the gap go to the tx_start register and the tx flop
  localparam logic [WAIT_W-1:0] GAP_LAST = WAIT_W'(GAP_CYC - 2);
  localparam logic [WAIT_W-1:0] TMO_LAST = WAIT_W'(TMO_CYC - 1);

  seq_state_t        state;
  logic              cmd_write;
  uart_byte_t        cmd_data;
  logic [WAIT_W-1:0] wait_cnt;
  logic              got_start;
  logic              accept;
  logic              gap_end;
  logic              rsp_take;
  logic              rsp_timeout;

  assign cmd_rdy     = (state == SEQ_IDLE);
  assign accept      = cmd_vld && cmd_rdy;
  assign gap_end     = (state == SEQ_GAP) && (wait_cnt == GAP_LAST);
  assign rsp_take    = (state == SEQ_WAIT_RSP) && got_start && rx_valid;
  // a start bit in the last cycle still counts as in time
  assign rsp_timeout = (state == SEQ_WAIT_RSP) && !got_start && !rx_start &&
                       (wait_cnt == TMO_LAST);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state     <= SEQ_IDLE;
      cmd_write <= 1'b0;
      wait_cnt  <= '0;
      got_start <= 1'b0;
      tx_start  <= 1'b0;
      read_rdy  <= 1'b0;
    end
    else
    begin
      tx_start <= 1'b0;
      read_rdy <= 1'b0;
      case (state)
        SEQ_IDLE:
        begin
          if (accept)
          begin
            state     <= SEQ_ADDR;
            cmd_write <= cmd_in[15];
            tx_start  <= 1'b1;
          end
        end
        SEQ_ADDR:
        begin
          if (tx_done)
          begin
            wait_cnt  <= '0;
            got_start <= 1'b0;
            state     <= cmd_write ? SEQ_GAP : SEQ_WAIT_RSP;
          end
        end
        SEQ_GAP:
        begin
          if (gap_end)
          begin
            state    <= SEQ_DATA;
            tx_start <= 1'b1;
          end
          else
          begin
            wait_cnt <= wait_cnt + 1'b1;
          end
        end
        SEQ_DATA:
        begin
          if (tx_done)
            state <= SEQ_IDLE;
        end
        SEQ_WAIT_RSP:
        begin
          if (rsp_take || rsp_timeout)
          begin
            state    <= SEQ_DONE;
            read_rdy <= 1'b1;
          end
          else if (!got_start)
          begin
            got_start <= rx_start;
            wait_cnt  <= wait_cnt + 1'b1;
          end
        end
        SEQ_DONE:
        begin
          state <= SEQ_IDLE;
        end
        default:
        begin
          state <= SEQ_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      tx_byte  <= cmd_in[15:8];
      cmd_data <= cmd_in[7:0];
    end
    else if (gap_end)
    begin
      tx_byte <= cmd_data;
    end

    if (rsp_take)
    begin
      read_data   <= rx_byte;
      read_status <= rx_status;
    end
    else if (rsp_timeout)
    begin
      read_data   <= '0;
      read_status <= RSP_TIMEOUT;
    end
  end

  a_tx_start_state: assert property (@(posedge clk) disable iff (!rst_n)
    tx_start |-> (state == SEQ_ADDR || state == SEQ_DATA))
    else $error("tx_start outside an address or data phase");

  a_read_busy: assert property (@(posedge clk) disable iff (!rst_n)
    read_rdy |-> !cmd_rdy)
    else $error("read result while a new command could be taken");

endmodule

//--- hdl/uart_pkg.sv
package uart_pkg;

  typedef logic [7:0] uart_byte_t;

  // precedence in the receiver is framing, then parity
  typedef enum logic [1:0] {
    RSP_OK      = 2'd0,
    RSP_PARITY  = 2'd1,
    RSP_FRAMING = 2'd2,
    RSP_TIMEOUT = 2'd3
  } rsp_status_t;

  typedef enum logic [2:0] {
    SEQ_IDLE     = 3'd0,
    SEQ_ADDR     = 3'd1,
    SEQ_GAP      = 3'd2,
    SEQ_DATA     = 3'd3,
    SEQ_WAIT_RSP = 3'd4,
    SEQ_DONE     = 3'd5
  } seq_state_t;

endpackage

//--- hdl/uart_rx_frame.sv
`timescale 1ns/10ps
`include "uart_cfg.svh"

module uart_rx_frame
  import uart_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        rx,
  output logic        rx_start,
  output logic        rx_valid,
  output uart_byte_t  rx_byte,
  output rsp_status_t rx_status
);

  localparam int DIV   = `UART_BAUD_DIV;
  localparam int CNT_W = $clog2(DIV);
  localparam logic [CNT_W-1:0] DIV_LAST = CNT_W'(DIV - 1);
  localparam logic [CNT_W-1:0] DIV_HALF = CNT_W'(DIV / 2);

  logic             rx_meta;
  logic             rx_sync;
  logic             rx_prev;
  logic             fall;
  logic             active;
  logic [CNT_W-1:0] div_cnt;
  logic [3:0]       bit_idx;
  logic             sample;
  uart_byte_t       shift_reg;
  logic             par_bit;

  // line idles high, so the flops come out of reset high
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end
    else
    begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  assign fall = rx_prev && !rx_sync;

  // start bit checked at half a bit, later bits a full bit apart
  assign sample = active && (div_cnt == ((bit_idx == 4'd0) ? DIV_HALF : DIV_LAST));

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      active   <= 1'b0;
      div_cnt  <= '0;
      bit_idx  <= '0;
      rx_start <= 1'b0;
      rx_valid <= 1'b0;
    end
    else
    begin
      rx_start <= 1'b0;
      rx_valid <= 1'b0;
      if (!active)
      begin
        if (fall)
        begin
          active  <= 1'b1;
          div_cnt <= '0;
          bit_idx <= '0;
        end
      end
      else if (sample)
      begin
        div_cnt <= '0;
        if (bit_idx == 4'd0)
        begin
          // glitch, back to idle without a report
          if (rx_sync)
          begin
            active <= 1'b0;
          end
          else
          begin
            rx_start <= 1'b1;
            bit_idx  <= 4'd1;
          end
        end
        else if (bit_idx == 4'd10)
        begin
          active   <= 1'b0;
          rx_valid <= 1'b1;
        end
        else
        begin
          bit_idx <= bit_idx + 4'd1;
        end
      end
      else
      begin
        div_cnt <= div_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (sample)
    begin
      if (bit_idx >= 4'd1 && bit_idx <= 4'd8)
        shift_reg <= {rx_sync, shift_reg[7:1]};
      if (bit_idx == 4'd9)
        par_bit <= rx_sync;
      if (bit_idx == 4'd10)
      begin
        rx_byte <= shift_reg;
        if (!rx_sync)
          rx_status <= RSP_FRAMING;
        else if (!(^{shift_reg, par_bit}))
          rx_status <= RSP_PARITY;
        else
          rx_status <= RSP_OK;
      end
    end
  end

  a_valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    rx_valid |=> !rx_valid)
    else $error("rx_valid held for more than one cycle");

endmodule

//--- hdl/uart_tx_frame.sv
`timescale 1ns/10ps
`include "uart_cfg.svh"

module uart_tx_frame
  import uart_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       tx_start,
  input  uart_byte_t tx_byte,
  output logic       tx_done,
  output logic       tx
);

  localparam int DIV   = `UART_BAUD_DIV;
  localparam int CNT_W = $clog2(DIV);
  localparam logic [CNT_W-1:0] DIV_LAST = CNT_W'(DIV - 1);

  logic             busy;
  logic [CNT_W-1:0] div_cnt;
  // 0 is the start bit, 10 the stop bit
  logic [3:0]       bit_idx;
  // data lsb first, then parity and stop
  logic [9:0]       shift_reg;
  logic             bit_end;

  assign bit_end = busy && (div_cnt == DIV_LAST);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy    <= 1'b0;
      div_cnt <= '0;
      bit_idx <= '0;
      tx      <= 1'b1;
    end
    else if (tx_start)
    begin
      busy    <= 1'b1;
      div_cnt <= '0;
      bit_idx <= '0;
      tx      <= 1'b0;
    end
    else if (busy)
    begin
      if (bit_end)
      begin
        div_cnt <= '0;
        if (bit_idx == 4'd10)
        begin
          busy <= 1'b0;
        end
        else
        begin
          bit_idx <= bit_idx + 4'd1;
          tx      <= shift_reg[0];
        end
      end
      else
      begin
        div_cnt <= div_cnt + 1'b1;
      end
    end
  end

  // odd parity over the data byte
  always_ff @(posedge clk)
  begin
    if (tx_start)
      shift_reg <= {1'b1, ~^tx_byte, tx_byte};
    else if (bit_end)
      shift_reg <= {1'b1, shift_reg[9:1]};
  end

  // last cycle of the stop bit
  assign tx_done = bit_end && (bit_idx == 4'd10);

  a_idle_high: assert property (@(posedge clk) disable iff (!rst_n)
    !busy |-> tx)
    else $error("tx line low while no frame is active");

  a_no_restart: assert property (@(posedge clk) disable iff (!rst_n)
    tx_start |-> !busy)
    else $error("tx_start arrived in the middle of a frame");

endmodule

//--- src.f
+incdir+hdl
hdl/uart_pkg.sv
hdl/uart_tx_frame.sv
hdl/uart_rx_frame.sv
hdl/uart_cmd_seq.sv
hdl/uart_cmd_bridge.sv
test/uart_remote_model.sv
test/tb_uart_cmd_bridge.sv

//--- test/tb_uart_cmd_bridge.sv
`timescale 1ns/10ps
`include "uart_cfg.svh"

module tb_uart_cmd_bridge
  import uart_pkg::*;
();

  localparam int DIV      = `UART_BAUD_DIV;
  localparam int NUM_CMDS = 50;
  // two frames, the gap and a full response timeout per command
  localparam int CMD_BITS = 2 * 11 + `UART_GAP_BITS + `UART_RSP_TIMEOUT_BITS;
  localparam longint WATCHDOG_NS = longint'(NUM_CMDS) * CMD_BITS * DIV * 10 + 200000;

  localparam logic [1:0] FAULT_NONE   = 2'd0;
  localparam logic [1:0] FAULT_PARITY = 2'd1;
  localparam logic [1:0] FAULT_STOP   = 2'd2;
  localparam logic [1:0] FAULT_SILENT = 2'd3;

  logic        clk;
  logic        rst_n;
  logic [15:0] cmd_in;
  logic        cmd_vld;
  logic        cmd_rdy;
  logic        rx;
  logic        tx;
  logic        read_rdy;
  uart_byte_t  read_data;
  rsp_status_t read_status;
  logic [1:0]  fault;
  logic        model_err;
  uart_byte_t  exp_regs [0:127];

  uart_cmd_bridge uart_cmd_bridge_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmd_in      (cmd_in),
    .cmd_vld     (cmd_vld),
    .cmd_rdy     (cmd_rdy),
    .rx          (rx),
    .tx          (tx),
    .read_rdy    (read_rdy),
    .read_data   (read_data),
    .read_status (read_status)
  );

  uart_remote_model remote_model_i (
    .clk   (clk),
    .tx    (tx),
    .fault (fault),
    .rx    (rx),
    .err   (model_err)
  );

  always #5 clk = ~clk;

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("error: %s is 0x%0h, expected 0x%0h", name, got, exp);
      $display("TEST RESULT: FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  // one command from handshake to completion, outputs sampled on the falling edge
  task automatic run_cmd(input logic wr, input logic [6:0] addr, input uart_byte_t data,
                         output uart_byte_t rd_data, output rsp_status_t rd_status);
    logic got_read;
    got_read  = 1'b0;
    rd_data   = '0;
    rd_status = RSP_OK;
    @(negedge clk);
    cmd_in  = {wr, addr, data};
    cmd_vld = 1'b1;
    while (!cmd_rdy)
      @(negedge clk);
    // taken on the rising edge in between
    @(negedge clk);
    cmd_vld = 1'b0;
    cmd_in  = '0;
    check_eq("cmd_rdy", cmd_rdy, 1'b0);
    check_eq("tx", tx, 1'b1);
    @(negedge clk);
    check_eq("tx", tx, 1'b0);
    while (!cmd_rdy)
    begin
      @(negedge clk);
      if (read_rdy)
      begin
        got_read  = 1'b1;
        rd_data   = read_data;
        rd_status = read_status;
        check_eq("cmd_rdy", cmd_rdy, 1'b0);
        @(negedge clk);
        check_eq("cmd_rdy", cmd_rdy, 1'b1);
      end
    end
    check_eq("read_rdy", got_read, !wr);
  endtask

  task automatic write_reg(input logic [6:0] addr, input uart_byte_t data);
    uart_byte_t  rd_data;
    rsp_status_t rd_status;
    run_cmd(1'b1, addr, data, rd_data, rd_status);
    exp_regs[addr] = data;
    check_eq("remote reg", remote_model_i.regs[addr], data);
  endtask

  task automatic read_reg(input logic [6:0] addr, input rsp_status_t exp_status,
                          input uart_byte_t exp_data);
    uart_byte_t  rd_data;
    rsp_status_t rd_status;
    run_cmd(1'b0, addr, 8'h00, rd_data, rd_status);
    check_eq("read_status", rd_status, exp_status);
    check_eq("read_data", rd_data, exp_data);
  endtask

  task automatic test_reset();
    check_eq("tx", tx, 1'b1);
    check_eq("cmd_rdy", cmd_rdy, 1'b1);
    check_eq("read_rdy", read_rdy, 1'b0);
  endtask

  task automatic test_write();
    write_reg(7'h00, 8'h3c);
    write_reg(7'h2a, 8'hc5);
    write_reg(7'h7f, 8'h81);
  endtask

  task automatic test_write_read();
    write_reg(7'h15, 8'h96);
    read_reg(7'h15, RSP_OK, 8'h96);
  endtask

  task automatic test_rsp_errors();
    @(negedge clk);
    fault = FAULT_PARITY;
    read_reg(7'h2a, RSP_PARITY, exp_regs[7'h2a]);
    fault = FAULT_STOP;
    read_reg(7'h7f, RSP_FRAMING, exp_regs[7'h7f]);
    fault = FAULT_NONE;
  endtask

  task automatic test_timeout_recover();
    @(negedge clk);
    fault = FAULT_SILENT;
    read_reg(7'h15, RSP_TIMEOUT, 8'h00);
    fault = FAULT_NONE;
    write_reg(7'h40, 8'h5e);
    read_reg(7'h40, RSP_OK, 8'h5e);
  endtask

  task automatic test_random_mix();
    logic       wr;
    logic [6:0] addr;
    uart_byte_t data;
    for (int n = 0; n < 40; n++)
    begin
      wr   = 1'($urandom % 2);
      addr = 7'($urandom % 128);
      data = 8'($urandom % 256);
      if (wr)
        write_reg(addr, data);
      else
        read_reg(addr, RSP_OK, exp_regs[addr]);
    end
  endtask

  initial
  begin
    @(posedge model_err);
    $display("TEST RESULT: FAIL");
    $fatal(1, "remote model rejected a frame");
  end

  initial
  begin
    #(WATCHDOG_NS);
    $display("watchdog expired, the run hung");
    $display("TEST RESULT: FAIL");
    $fatal(1, "timeout");
  end

  initial
  begin
    void'($urandom(32'ha995));
    clk     = 1'b0;
    rst_n   = 1'b0;
    cmd_vld = 1'b0;
    cmd_in  = '0;
    fault   = FAULT_NONE;
    // power-up contents of the remote registers
    for (int i = 0; i < 128; i++)
      exp_regs[i] = uart_byte_t'(i * 37 + 11);
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    test_reset();
    test_write();
    test_write_read();
    test_rsp_errors();
    test_timeout_recover();
    test_random_mix();
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

//--- test/uart_remote_model.sv
`timescale 1ns/10ps
`include "uart_cfg.svh"

module uart_remote_model
  import uart_pkg::*;
(
  input  logic       clk,
  input  logic       tx,
  input  logic [1:0] fault,
  output logic       rx,
  output logic       err
);

  localparam int DIV = `UART_BAUD_DIV;
  localparam logic [1:0] FAULT_PARITY = 2'd1;
  localparam logic [1:0] FAULT_STOP   = 2'd2;
  localparam logic [1:0] FAULT_SILENT = 2'd3;

  uart_byte_t regs [0:127];
  uart_byte_t addr_byte;
  uart_byte_t data_byte;

  task automatic flag_error(input string msg);
    $display("remote model: %s", msg);
    err = 1'b1;
  endtask

  // samples at mid-bit on the falling clock edge
  task automatic recv_frame(output uart_byte_t value);
    logic par;
    @(negedge tx);
    repeat (DIV / 2) @(negedge clk);
    if (tx !== 1'b0)
      flag_error("start bit was not low at mid-bit");
    for (int i = 0; i < 8; i++)
    begin
      repeat (DIV) @(negedge clk);
      value[i] = tx;
    end
    repeat (DIV) @(negedge clk);
    par = tx;
    if ((^{value, par}) !== 1'b1)
      flag_error("frame from the bridge broke odd parity");
    repeat (DIV) @(negedge clk);
    if (tx !== 1'b1)
      flag_error("frame from the bridge had a low stop bit");
  endtask

  task automatic send_frame(input uart_byte_t value);
    logic par;
    logic stop;
    par  = ~^value;
    stop = 1'b1;
    if (fault == FAULT_PARITY)
      par = ~par;
    // low stop also flips parity
    if (fault == FAULT_STOP)
    begin
      par  = ~par;
      stop = 1'b0;
    end
    rx = 1'b0;
    repeat (DIV) @(negedge clk);
    for (int i = 0; i < 8; i++)
    begin
      rx = value[i];
      repeat (DIV) @(negedge clk);
    end
    rx = par;
    repeat (DIV) @(negedge clk);
    rx = stop;
    repeat (DIV) @(negedge clk);
    rx = 1'b1;
  endtask

  // turnaround of four bit times before the reply frame
  task automatic send_reply(input logic [6:0] addr);
    repeat (4 * DIV) @(negedge clk);
    send_frame(regs[addr]);
  endtask

  initial
  begin
    rx  = 1'b1;
    err = 1'b0;
    for (int i = 0; i < 128; i++)
      regs[i] = uart_byte_t'(i * 37 + 11);
  end

  always
  begin
    recv_frame(addr_byte);
    if (addr_byte[7])
    begin
      recv_frame(data_byte);
      regs[addr_byte[6:0]] = data_byte;
    end
    else if (fault != FAULT_SILENT)
    begin
      // next request may start during the reply's stop bit
      fork
        send_reply(addr_byte[6:0]);
      join_none
    end
  end

endmodule
